// File: logic/busPkg.sv
package busPkg;

// ==========================================================================
// bus operation and status codes
// ==========================================================================

typedef enum logic [4:0]
{
	opmReady  = 5'b00000,	// idle, no request
	opmLoadX  = 5'b00111,	// 128-bit load
	opmLoadQ  = 5'b01011,	// 64-bit load
	opmStoreX = 5'b10111,	// 128-bit store
	opmStoreQ = 5'b10011	// 64-bit store
} memOpm;

typedef enum logic [1:0]
{
	okReady = 2'b00,
	okDone  = 2'b01,	// data valid
	okHold  = 2'b10,	// still busy
	okFault = 2'b11		// see busExc
} memOk;

typedef enum logic [15:0]
{
	excNone  = 16'h0000,
	excRange = 16'h8001
} excCode;

// ==========================================================================
// request and response bundles
// ==========================================================================

typedef struct packed
{
	logic [127:0] outData;
	logic [47:0]  addrA;
	logic [47:0]  addrB;	// next line, for quads that spill over
	memOpm        opm;
} busReq;

typedef struct packed
{
	logic [127:0] inData;
	memOk         ok;
	logic [63:0]  busExc;	// {address, code}
} busRsp;

function automatic logic isQuad(input memOpm opm);
	return (opm == opmLoadQ) || (opm == opmStoreQ);
endfunction

function automatic logic isStore(input memOpm opm);
	return (opm == opmStoreQ) || (opm == opmStoreX);
endfunction

// exception word, faulting address above the code
function automatic logic [63:0] packExc(input excCode code, input logic [47:0] addr);
	return {addr, code};
endfunction

endpackage

// File: logic/memPkg.sv
package memPkg;

// ==========================================================================
// line memory geometry
// ==========================================================================

localparam int LineBytes  = 16;
localparam int IndexWidth = 44;	// address bits 47..4

typedef logic [127:0]          memLine;
typedef logic [IndexWidth-1:0] lineIdx;
typedef logic [3:0]            byteOff;

function automatic lineIdx lineIndex(input logic [47:0] addr);
	return addr[47:4];
endfunction

function automatic byteOff byteOffset(input logic [47:0] addr);
	return addr[3:0];
endfunction

// true when an access of this size runs past the end of its line
function automatic logic crossesLine(input byteOff offset, input int bytes);
	return (int'(offset) + bytes) > LineBytes;
endfunction

endpackage

// File: logic/MemPortJoin.sv
`timescale 1ns/100ps

module MemPortJoin
	import busPkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  busReq port1Req,
	input  busReq port2Req,
	input  busRsp memRsp,
	output busRsp port1Rsp,
	output busRsp port2Rsp,
	output busReq memReq
);

logic  own1;		// port1 holds the memory
logic  own2;
logic  active1;
logic  active2;
logic  take1;
logic  take2;
logic  nextOwn1;
logic  nextOwn2;

busReq nextReq;
busRsp nextRsp1;
busRsp nextRsp2;

busReq reqReg;
busRsp rsp1Reg;
busRsp rsp2Reg;

// owner sees memory status once the memory has picked up its request,
// everyone else sees hold while requesting and ready while idle
function automatic busRsp portResponse(
	input logic  taken,
	input logic  active,
	input busRsp mem
);
	busRsp rsp;

	rsp.inData = mem.inData;	// read data goes to both ports
	if (taken && (mem.ok != okReady))
	begin
		rsp.ok     = mem.ok;
		rsp.busExc = mem.busExc;
	end
	else
	begin
		if (active)
			rsp.ok = okHold;
		else
			rsp.ok = okReady;
		rsp.busExc = '0;
	end
	return rsp;
endfunction

// ==========================================================================
// arbitration
// ==========================================================================

always_comb
begin
	active1 = port1Req.opm != opmReady;
	active2 = port2Req.opm != opmReady;

	take1 = own1 || (active1 && !own2);
	take2 = own2 || (active2 && !take1);	// port1 wins a tie

	// hold on until both request and memory are back to ready
	nextOwn1 = take1 && (active1 || (memRsp.ok != okReady));
	nextOwn2 = take2 && (active2 || (memRsp.ok != okReady));

	nextReq     = port1Req;
	nextReq.opm = opmReady;
	if (take1)
		nextReq = port1Req;
	else if (take2)
		nextReq = port2Req;

	nextRsp1 = portResponse(take1, active1, memRsp);
	nextRsp2 = portResponse(take2, active2, memRsp);
end

// ==========================================================================
// output registers
// ==========================================================================

always_ff @(posedge clock)
begin
	reqReg  <= nextReq;
	rsp1Reg <= nextRsp1;
	rsp2Reg <= nextRsp2;

	if (reset)
	begin
		own1        <= 1'b0;
		own2        <= 1'b0;
		reqReg.opm  <= opmReady;
		rsp1Reg.ok  <= okReady;
		rsp2Reg.ok  <= okReady;
	end
	else
	begin
		own1 <= nextOwn1;
		own2 <= nextOwn2;
	end
end

assign memReq   = reqReg;
assign port1Rsp = rsp1Reg;
assign port2Rsp = rsp2Reg;

endmodule

// File: logic/LineMemory.sv
`timescale 1ns/100ps

module LineMemory
	import busPkg::*;
	import memPkg::*;
#(
	parameter int WaitStates = 2,
	parameter int LineCount  = 256
)
(
	input  logic  clock,
	input  logic  reset,
	input  busReq memReq,
	output busRsp memRsp
);

localparam int LineBits  = (LineCount > 1) ? $clog2(LineCount) : 1;
localparam int CountBits = (WaitStates > 1) ? $clog2(WaitStates) : 1;

typedef enum logic [1:0]
{
	stIdle,
	stWait,
	stDone,
	stDrain		// turnaround after the requester lets go
} memState;

memLine               lines [LineCount];

memState              state;
logic [CountBits-1:0] waitCount;
memOk                 rspOk;
logic [127:0]         rspData;
logic [63:0]          rspExc;

lineIdx               idxA;
lineIdx               idxB;
byteOff               offset;
logic                 quad;
logic                 store;
logic                 crossing;
logic                 faultA;
logic                 faultB;
logic                 fault;
logic                 doAccess;
memLine               lineA;
memLine               lineB;
logic [255:0]         pair;
logic [255:0]         merged;
logic [127:0]         loadData;
logic [63:0]          faultExc;

// ==========================================================================
// address decode and data steering
// ==========================================================================

always_comb
begin
	idxA     = lineIndex(memReq.addrA);
	idxB     = lineIndex(memReq.addrB);
	offset   = byteOffset(memReq.addrA);
	quad     = isQuad(memReq.opm);
	store    = isStore(memReq.opm);
	crossing = quad && crossesLine(offset, 8);

	faultA = idxA >= lineIdx'(LineCount);
	faultB = crossing && (idxB >= lineIdx'(LineCount));	// addrB only matters on a spill
	fault  = faultA || faultB;

	lineA = lines[idxA[LineBits-1:0]];
	lineB = lines[idxB[LineBits-1:0]];
	pair  = {lineB, lineA};

	// quad store merged into the line pair
	merged = pair;
	merged[{offset, 3'b000} +: 64] = memReq.outData[63:0];

	if (quad)
		loadData = {64'h0, pair[{offset, 3'b000} +: 64]};
	else
		loadData = lineA;

	faultExc = packExc(excRange, faultA ? memReq.addrA : memReq.addrB);
end

assign doAccess = ((state == stWait) && (waitCount == '0)) ||
	((state == stIdle) && (memReq.opm != opmReady) && (WaitStates == 0));

// ==========================================================================
// control
// ==========================================================================

always_ff @(posedge clock)
begin
	if (reset)
	begin
		state     <= stIdle;
		waitCount <= '0;
		rspOk     <= okReady;
	end
	else if (doAccess)
	begin
		rspOk <= fault ? okFault : okDone;
		state <= stDone;
	end
	else
	begin
		case (state)
			stIdle:
				if (memReq.opm != opmReady)
				begin
					rspOk     <= okHold;
					waitCount <= CountBits'(WaitStates - 1);
					state     <= stWait;
				end
			stWait:
				waitCount <= waitCount - 1'b1;
			stDone:
				if (memReq.opm == opmReady)
				begin
					rspOk <= okReady;
					state <= stDrain;
				end
			stDrain:
				state <= stIdle;
		endcase
	end
end

// array and response payload
always_ff @(posedge clock)
begin
	if (doAccess)
	begin
		rspData <= fault ? '0 : loadData;
		rspExc  <= fault ? faultExc : packExc(excNone, 48'h0);
		if (store && !fault)
		begin
			if (quad)
			begin
				lines[idxA[LineBits-1:0]] <= merged[127:0];
				if (crossing)
					lines[idxB[LineBits-1:0]] <= merged[255:128];	// upper bytes spill over
			end
			else
				lines[idxA[LineBits-1:0]] <= memReq.outData;
		end
	end
end

assign memRsp = '{inData: rspData, ok: rspOk, busExc: rspExc};

endmodule

// File: logic/MemSubsys.sv
`timescale 1ns/100ps

module MemSubsys
	import busPkg::*;
#(
	parameter int WaitStates = 2,
	parameter int LineCount  = 256
)
(
	input  logic  clock,
	input  logic  reset,
	input  busReq port1Req,	// data side
	input  busReq port2Req,	// fetch side
	output busRsp port1Rsp,
	output busRsp port2Rsp
);

busReq memReq;
busRsp memRsp;

// ==========================================================================
// requester join, then the memory stage
// ==========================================================================

MemPortJoin uJoin
(
	.clock    (clock),
	.reset    (reset),
	.port1Req (port1Req),
	.port2Req (port2Req),
	.memRsp   (memRsp),
	.port1Rsp (port1Rsp),
	.port2Rsp (port2Rsp),
	.memReq   (memReq)
);

LineMemory #(
	.WaitStates (WaitStates),
	.LineCount  (LineCount)
) uMem
(
	.clock  (clock),
	.reset  (reset),
	.memReq (memReq),
	.memRsp (memRsp)
);

endmodule

// File: verification/TbMemSubsys.sv
`timescale 1ns/100ps

module TbMemSubsys
	import busPkg::*;
	import memPkg::*;
();

localparam int WaitStates    = 2;
localparam int LineCount     = 256;
localparam int Period        = 100;
localparam int TxnCount      = 100;	// upper bound on transactions in the run
localparam int StatusTimeout = 4 * (WaitStates + 12);	// cycles, covers one contender
localparam int WatchdogTime  = (TxnCount * (WaitStates + 12) + 100) * Period;

logic        clock;
logic        reset;
busReq       req1;
busReq       req2;
busRsp       rsp1;
busRsp       rsp2;

memLine      modelMem [LineCount];	// expected memory contents
logic [31:0] lfsrState;
int          valueErrors;
int          timeouts;

MemSubsys #(
	.WaitStates (WaitStates),
	.LineCount  (LineCount)
) u_dut
(
	.clock    (clock),
	.reset    (reset),
	.port1Req (req1),
	.port2Req (req2),
	.port1Rsp (rsp1),
	.port2Rsp (rsp2)
);

always #(Period / 2) clock = ~clock;

// ==========================================================================
// helpers
// ==========================================================================

// galois shift, one step per bit
function automatic logic [127:0] randomBits(input int count);
	logic [127:0] bits;
	bits = '0;
	for (int i = 0; i < count; i++)
	begin
		bits[i] = lfsrState[0];
		lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
	end
	return bits;
endfunction

function automatic logic [47:0] lineAddr(input int line, input int offset);
	return (48'(line) << 4) + 48'(offset);
endfunction

// eight bytes from offset on, spilling into the next line
function automatic logic [63:0] modelQuadRead(input int line, input int offset);
	logic [63:0] value;
	int          b;
	for (int i = 0; i < 8; i++)
	begin
		b = offset + i;
		if (b < 16)
			value[i*8 +: 8] = modelMem[line][b*8 +: 8];
		else
			value[i*8 +: 8] = modelMem[line + 1][(b - 16)*8 +: 8];
	end
	return value;
endfunction

function automatic void modelQuadWrite(input int line, input int offset, input logic [63:0] value);
	int b;
	for (int i = 0; i < 8; i++)
	begin
		b = offset + i;
		if (b < 16)
			modelMem[line][b*8 +: 8] = value[i*8 +: 8];
		else
			modelMem[line + 1][(b - 16)*8 +: 8] = value[i*8 +: 8];
	end
endfunction

function automatic busRsp portRsp(input int port);
	return (port == 1) ? rsp1 : rsp2;
endfunction

task automatic driveReq(input int port, input busReq req);
	if (port == 1)
		req1 = req;
	else
		req2 = req;
endtask

task automatic noteFailure(input string msg);
	$display("Fail at %0t ns: %s", $time, msg);
	valueErrors++;
endtask

// ==========================================================================
// one bus transaction: wait ready, request, wait result, release
// ==========================================================================

task automatic runTransaction(
	input  int           port,
	input  memOpm        opm,
	input  logic [47:0]  addrA,
	input  logic [47:0]  addrB,
	input  logic [127:0] data,
	input  memOk         expOk,
	input  logic [127:0] expData,	// loads only
	input  logic [63:0]  expExc,
	output time          doneTime,
	output time          readyTime
);
	busReq req;
	busRsp rsp;
	int    waited;

	@(posedge clock);
	#1;
	waited = 0;
	rsp = portRsp(port);
	while (rsp.ok != okReady && waited < StatusTimeout)
	begin
		@(posedge clock);
		#1;
		rsp = portRsp(port);
		waited++;
	end
	if (rsp.ok != okReady)
	begin
		$display("port %0d was not ready when a new request was due", port);
		timeouts++;
	end

	req.outData = data;
	req.addrA   = addrA;
	req.addrB   = addrB;
	req.opm     = opm;
	driveReq(port, req);

	waited = 0;
	@(posedge clock);
	#1;
	rsp = portRsp(port);
	while (rsp.ok == okHold && waited < StatusTimeout)
	begin
		@(posedge clock);
		#1;
		rsp = portRsp(port);
		waited++;
	end
	doneTime = $time;
	if (rsp.ok == okHold)
	begin
		$display("port %0d got no answer to its %s within %0d cycles", port, opm.name(),
			StatusTimeout);
		timeouts++;
	end
	else
	begin
		if (rsp.ok !== expOk)
			noteFailure($sformatf("port %0d %s status %s, expected %s", port, opm.name(),
				rsp.ok.name(), expOk.name()));
		if (opm == opmLoadX && rsp.ok == okDone && rsp.inData !== expData)
			noteFailure($sformatf("port %0d line at %h read %h, expected %h", port, addrA,
				rsp.inData, expData));
		if (opm == opmLoadQ && rsp.ok == okDone && rsp.inData[63:0] !== expData[63:0])
			noteFailure($sformatf("port %0d quad at %h read %h, expected %h", port, addrA,
				rsp.inData[63:0], expData[63:0]));
		if (rsp.busExc !== expExc)
			noteFailure($sformatf("port %0d exception word %h, expected %h", port,
				rsp.busExc, expExc));
	end

	req.opm = opmReady;
	driveReq(port, req);
	waited = 0;
	while (rsp.ok != okReady && waited < StatusTimeout)
	begin
		@(posedge clock);
		#1;
		rsp = portRsp(port);
		if (rsp.ok == okHold)
			noteFailure($sformatf("port %0d went back to hold after retiring", port));
		waited++;
	end
	readyTime = $time;
	if (rsp.ok != okReady)
	begin
		$display("port %0d never returned to ready after its transaction", port);
		timeouts++;
	end
endtask

task automatic storeLine(input int port, input int line, input logic [127:0] data);
	time t0;
	time t1;
	runTransaction(port, opmStoreX, lineAddr(line, 0), lineAddr(line + 1, 0), data,
		okDone, '0, '0, t0, t1);
	modelMem[line] = data;
endtask

task automatic loadLine(input int port, input int line);
	time t0;
	time t1;
	runTransaction(port, opmLoadX, lineAddr(line, 0), lineAddr(line + 1, 0), '0,
		okDone, modelMem[line], '0, t0, t1);
endtask

task automatic storeQuad(input int port, input int line, input int offset,
	input logic [127:0] data);
	time t0;
	time t1;
	runTransaction(port, opmStoreQ, lineAddr(line, offset), lineAddr(line + 1, 0), data,
		okDone, '0, '0, t0, t1);
	modelQuadWrite(line, offset, data[63:0]);
endtask

task automatic loadQuad(input int port, input int line, input int offset);
	time t0;
	time t1;
	runTransaction(port, opmLoadQ, lineAddr(line, offset), lineAddr(line + 1, 0), '0,
		okDone, {64'h0, modelQuadRead(line, offset)}, '0, t0, t1);
endtask

// ==========================================================================
// directed tests
// ==========================================================================

task automatic testOctoLines();
	int lines [4] = '{3, 7, 100, 255};
	for (int port = 1; port <= 2; port++)
		for (int k = 0; k < 4; k++)
		begin
			storeLine(port, lines[k] - (port - 1), randomBits(128));
			loadLine(port, lines[k] - (port - 1));
		end
endtask

task automatic testQuadOffsets();
	storeLine(1, 16, randomBits(128));
	storeLine(1, 17, randomBits(128));
	for (int off = 0; off < 16; off++)
	begin
		storeQuad(1 + (off % 2), 16, off, randomBits(128));
		loadQuad(1 + (off % 2), 16, off);
		loadLine(1, 16);	// neighbours on both lines
		loadLine(2, 17);
	end
endtask

task automatic testSameCycle();
	logic [127:0] data;
	time          done1;
	time          ready1;
	time          done2;
	time          ready2;
	data = randomBits(128);
	fork
		runTransaction(1, opmStoreX, lineAddr(50, 0), lineAddr(51, 0), data,
			okDone, '0, '0, done1, ready1);
		runTransaction(2, opmLoadX, lineAddr(3, 0), lineAddr(4, 0), '0,
			okDone, modelMem[3], '0, done2, ready2);
	join
	modelMem[50] = data;
	if (done2 <= ready1)
		noteFailure("port2 finished before port1 had retired");
	loadLine(2, 50);
endtask

task automatic testRangeFault();
	logic [47:0]  badA;
	logic [47:0]  badB;
	logic [127:0] data;
	time          t0;
	time          t1;
	storeLine(1, 2, randomBits(128));
	badA = lineAddr(LineCount + 2, 0);	// low index bits match line 2
	runTransaction(1, opmStoreX, badA, badA + 48'd16, randomBits(128),
		okFault, '0, {badA, excRange}, t0, t1);
	loadLine(1, 2);
	runTransaction(2, opmLoadQ, badA + 48'd4, badA + 48'd16, '0,
		okFault, '0, {badA + 48'd4, excRange}, t0, t1);

	// crossing quad whose second line is past the end
	badB = lineAddr(LineCount, 0);
	runTransaction(1, opmStoreQ, lineAddr(LineCount - 1, 12), badB, randomBits(128),
		okFault, '0, {badB, excRange}, t0, t1);
	loadLine(2, LineCount - 1);

	// quad that ends exactly at the line end never touches addrB
	data = randomBits(128);
	runTransaction(1, opmStoreQ, lineAddr(LineCount - 1, 8), badB, data,
		okDone, '0, '0, t0, t1);
	modelQuadWrite(LineCount - 1, 8, data[63:0]);
	loadLine(1, LineCount - 1);
endtask

task automatic testReadyStatus();
	logic busy;
	time  t0;
	time  t1;
	for (int i = 0; i < 4; i++)
	begin
		@(posedge clock);
		#1;
		if (rsp1.ok != okReady || rsp2.ok != okReady)
			noteFailure("an idle port is not showing ready");
	end
	storeLine(1, 7, randomBits(128));
	busy = 1'b1;
	fork
		begin
			runTransaction(1, opmLoadX, lineAddr(7, 0), lineAddr(8, 0), '0,
				okDone, modelMem[7], '0, t0, t1);
			busy = 1'b0;
		end
		while (busy)
		begin
			@(posedge clock);
			#1;
			if (rsp2.ok != okReady)
				noteFailure("idle port2 left ready while port1 was busy");
		end
	join
	loadLine(1, 7);
	loadLine(1, 7);	// back to back, each must start from ready
endtask

initial
begin
	clock = 1'b0;
	reset = 1'b1;
	req1 = '0;
	req2 = '0;
	lfsrState = 32'h2c1c_dcab;
	valueErrors = 0;
	timeouts = 0;
	repeat (5) @(posedge clock);
	#1;
	reset = 1'b0;

	testReadyStatus();
	testOctoLines();
	testQuadOffsets();
	testSameCycle();
	testRangeFault();

	$display("value errors: %0d, timeouts: %0d", valueErrors, timeouts);
	if (valueErrors == 0 && timeouts == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

initial
begin
	#(WatchdogTime);
	$display("watchdog expired, tests did not finish within %0d ns", WatchdogTime);
	$display(">>> FAIL");
	$finish;
end

endmodule

// File: sim.f
logic/busPkg.sv
logic/memPkg.sv
logic/MemPortJoin.sv
logic/LineMemory.sv
logic/MemSubsys.sv
verification/TbMemSubsys.sv

// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -j 0 -Wno-fatal
TOP      = TbMemSubsys
FILELIST = sim.f
OBJDIR   = obj_dir
PASSTEXT = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# passes only when the testbench printed the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASSTEXT)'

clean:
	rm -rf $(OBJDIR)
